// ==== sources.f ====
+incdir+include
hdl/cartDetectPkg.sv
hdl/cartDetectIfs.sv
hdl/byteWindow.sv
hdl/signatureMatcher.sv
hdl/superChipCheck.sv
hdl/bankClassifier.sv
hdl/cartDetect.sv
verification/cartDetectModelPkg.sv
verification/cartDetectTb.sv

// ==== verification/cartDetectTb.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module cartDetectTb;

	localparam int NumImages = 40;
	localparam int CycleLimit = NumImages * (8192 + 64) * 2;
	localparam int SizeChoices = 18;

	// Size thresholds and their neighbors
	localparam logic [`CD_SIZE_W-1:0] sizeTable [SizeChoices] = '{
		32'h0000_07FF, 32'h0000_0800, 32'h0000_0801, 32'h0000_0FFF, 32'h0000_1000,
		32'h0000_1001, 32'h0000_1FFF, 32'h0000_2000, 32'h0000_2001, 32'h0000_3000,
		32'h0000_3001, 32'h0000_4000, 32'h0000_4001, 32'h0000_8000, 32'h0000_8001,
		32'h0000_FFFF, 32'h0001_0000, 32'h0001_0001
	};
	localparam logic [`CD_SIZE_W-1:0] scSizes [3] = '{`CD_SIZE_8K, `CD_SIZE_16K, `CD_SIZE_32K};

	logic clk;
	logic reset;
	logic enable;
	logic [`CD_ADDR_W-1:0] addr;
	logic [`CD_DATA_W-1:0] data;
	logic [`CD_SIZE_W-1:0] cartSize;
	logic [`CD_BANK_CODE_W-1:0] bankType;
	logic superChip;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int imageLen;                  // Bytes streamed for the current image

	cartDetect DUT (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.addr(addr),
		.data(data),
		.cartSize(cartSize),
		.bankType(bankType),
		.superChip(superChip)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------
	task automatic driveCycle(input logic en, input logic [`CD_ADDR_W-1:0] a,
		input logic [`CD_DATA_W-1:0] d);
		@(posedge clk);
		#1;
		enable = en;
		addr = a;
		data = d;
	endtask

	// Random member of one signature family
	function automatic int pickSignature(input int fam);
		int n;
		int k;
		n = 0;
		for (int s = 0; s < `CD_SIG_COUNT; s++)
			if (cartDetectPkg::sigFamily[s] == fam)
				n++;
		k = $urandom % n;
		for (int s = 0; s < `CD_SIG_COUNT; s++) begin
			if (cartDetectPkg::sigFamily[s] == fam) begin
				if (k == 0)
					return s;
				k--;
			end
		end
		return 0;
	endfunction

	// Slots 0 to 2 split the image past the RAM area, so copies never overlap
	function automatic void placeSignature(input int s, input int slot);
		int span;
		int pos;
		int len;
		span = (imageLen - 520) / 3;
		pos = 512 + slot * span + int'($urandom % (span - 8));
		len = cartDetectPkg::sigLength[s];
		for (int b = 0; b < len; b++)
			cartDetectModelPkg::image[pos + b] = cartDetectPkg::sigBytes[s][8*(len-1-b) +: 8];
	endfunction

	task automatic injectSignatures(input int kind);
		int s;
		case (kind)
			4: placeSignature(pickSignature(cartDetectPkg::FAM_E0), 1);
			5: placeSignature(pickSignature(cartDetectPkg::FAM_E7), 1);
			6: placeSignature(pickSignature(cartDetectPkg::FAM_CV), 1);
			7: placeSignature(pickSignature(cartDetectPkg::FAM_UA), 1);
			8: placeSignature(pickSignature(cartDetectPkg::FAM_FE), 1);
			9: begin
				placeSignature(pickSignature(cartDetectPkg::FAM_FE), 0);
				s = pickSignature(cartDetectPkg::FAM_F8);    // Same hotspot twice vetoes FE
				placeSignature(s, 1);
				placeSignature(s, 2);
			end
			10: placeSignature(pickSignature(cartDetectPkg::FAM_3F), 1);
			11: begin
				s = pickSignature(cartDetectPkg::FAM_3F);
				placeSignature(s, 0);
				placeSignature(s, 2);
			end
			default: ;    // Plain random image
		endcase
	endtask

	// Copy low half onto high half in banks 0 and 1, maybe spoil one byte
	task automatic mirrorBanks(input bit spoil);
		int base;
		for (int bank = 0; bank < 2; bank++) begin
			base = bank * `CD_BANK1_BASE;
			for (int i = 0; i < `CD_SC_HALF; i++)
				cartDetectModelPkg::image[base + `CD_SC_HALF + i] = cartDetectModelPkg::image[base + i];
		end
		if (spoil) begin
			base = `CD_SC_HALF + int'($urandom % `CD_SC_HALF) + int'($urandom % 2) * `CD_BANK1_BASE;
			cartDetectModelPkg::image[base] = cartDetectModelPkg::image[base] ^ 8'h5A;
		end
	endtask

	// Bytes from address 0 with random gaps, then idle past the pipeline depth
	task automatic streamImage();
		for (int i = 0; i < imageLen; i++) begin
			while ($urandom % 8 == 0)
				driveCycle(1'b0, `CD_ADDR_W'(i), 8'h00);
			driveCycle(1'b1, `CD_ADDR_W'(i), cartDetectModelPkg::image[i]);
		end
		repeat (4)
			driveCycle(1'b0, '0, 8'h00);
	endtask

	task automatic checkResult(input int img, input int kind);
		logic [cartDetectPkg::FAM_COUNT-1:0] fam;
		logic [`CD_BANK_CODE_W-1:0] expType;
		bit expSc;
		fam = cartDetectModelPkg::familiesFired(imageLen);
		expType = cartDetectModelPkg::expectedType(fam, cartSize);
		expSc = cartDetectModelPkg::expectedSuperChip(expType, imageLen);
		checks += 2;
		assert (bankType == expType) else begin
			errors++;
			$display("Fail %0t: image %0d kind %0d size %h bankType %0d expected %0d",
				$time, img, kind, cartSize, bankType, expType);
		end
		assert (superChip == expSc) else begin
			errors++;
			$display("Fail %0t: image %0d kind %0d size %h superChip %0b expected %0b",
				$time, img, kind, cartSize, superChip, expSc);
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int kind;
		bit mirror;
		void'($urandom(32'h87dab2fa));
		reset = 1'b1;
		enable = 1'b0;
		addr = '0;
		data = '0;
		cartSize = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		checks++;
		assert (bankType == cartDetectPkg::BANK_NONE && superChip == 1'b0) else begin
			errors++;
			$display("Fail %0t: outputs not cleared by reset", $time);
		end
		// No reset between images, each one restarts at address 0
		for (int img = 0; img < NumImages; img++) begin
			kind = $urandom % 12;
			if (kind < 3)
				cartSize = scSizes[$urandom % 3];    // Good SuperChip candidates
			else if ((kind == 4 || kind == 7) && $urandom % 2 == 1)
				cartSize = `CD_SIZE_8K;              // E0 and UA need exactly 8K
			else
				cartSize = sizeTable[$urandom % SizeChoices];
			imageLen = (cartSize > `CD_SIZE_8K) ? 8192 : int'(cartSize);
			for (int i = 0; i < imageLen; i++)
				cartDetectModelPkg::image[i] = 8'($urandom);
			injectSignatures(kind);
			mirror = ($urandom % 3 != 0);
			if (mirror)
				mirrorBanks($urandom % 4 == 0);
			streamImage();
			checkResult(img, kind);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/cartDetectModelPkg.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

package cartDetectModelPkg;

	localparam int ImageMax = 8192;

	logic [`CD_DATA_W-1:0] image [ImageMax];    // Image exactly as the loader streams it

	// Bytes before address 0 read as zero, like a freshly restarted window
	function automatic logic [`CD_DATA_W-1:0] byteAt(input int pos);
		if (pos < 0)
			return '0;
		return image[pos];
	endfunction

	// Signature s has its last byte at stream position pos
	function automatic bit sigEndsAt(input int s, input int pos);
		for (int b = 0; b < cartDetectPkg::sigLength[s]; b++) begin
			if (byteAt(pos - b) != cartDetectPkg::sigBytes[s][8*b +: 8])
				return 1'b0;    // Newest byte checked first, most scans stop here
		end
		return 1'b1;
	endfunction

	// ------------------------------------------------------------------------
	// Families whose signatures reached their occurrence count
	// ------------------------------------------------------------------------
	function automatic logic [cartDetectPkg::FAM_COUNT-1:0] familiesFired(input int len);
		int hits [`CD_SIG_COUNT];
		logic [cartDetectPkg::FAM_COUNT-1:0] fam;
		for (int s = 0; s < `CD_SIG_COUNT; s++)
			hits[s] = 0;
		for (int pos = 0; pos < len; pos++) begin
			for (int s = 0; s < `CD_SIG_COUNT; s++) begin
				if (sigEndsAt(s, pos))
					hits[s]++;
			end
		end
		fam = '0;
		for (int s = 0; s < `CD_SIG_COUNT; s++) begin
			if (hits[s] >= cartDetectPkg::sigNeeded[s])
				fam[cartDetectPkg::sigFamily[s]] = 1'b1;
		end
		return fam;
	endfunction

	// Second 128 bytes of a bank repeat the first 128
	function automatic bit bankMirrored(input int base);
		for (int i = 0; i < `CD_SC_HALF; i++) begin
			if (image[base + i] != image[base + `CD_SC_HALF + i])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// A bank only gives a verdict once its byte at offset 256 went by
	function automatic bit superChipSeen(input int len);
		bit sc;
		sc = 1'b0;
		if (len > `CD_SC_END)
			sc = bankMirrored(0);
		if (len > `CD_BANK1_BASE + `CD_SC_END)
			sc = sc & bankMirrored(`CD_BANK1_BASE);
		return sc;
	endfunction

	// ------------------------------------------------------------------------
	// Classifier rules, first one that holds wins
	// ------------------------------------------------------------------------
	function automatic logic [`CD_BANK_CODE_W-1:0] expectedType(
		input logic [cartDetectPkg::FAM_COUNT-1:0] fam,
		input logic [`CD_SIZE_W-1:0] size
	);
		if (fam[cartDetectPkg::FAM_FE] && !fam[cartDetectPkg::FAM_F8])
			return cartDetectPkg::BANK_FE;
		if (fam[cartDetectPkg::FAM_E0] && size == `CD_SIZE_8K)
			return cartDetectPkg::BANK_E0;
		if (fam[cartDetectPkg::FAM_3F] && size > `CD_SIZE_4K)
			return cartDetectPkg::BANK_3F;
		if (fam[cartDetectPkg::FAM_CV])
			return cartDetectPkg::BANK_CV;
		if (fam[cartDetectPkg::FAM_E7])
			return cartDetectPkg::BANK_E7;
		if (fam[cartDetectPkg::FAM_UA] && size == `CD_SIZE_8K)
			return cartDetectPkg::BANK_UA;
		if (size <= `CD_SIZE_2K)
			return cartDetectPkg::BANK_2K;
		if (size <= `CD_SIZE_4K)
			return cartDetectPkg::BANK_4K;
		if (size <= `CD_SIZE_8K)
			return cartDetectPkg::BANK_F8;
		if (size <= `CD_SIZE_12K)
			return cartDetectPkg::BANK_FA;
		if (size <= `CD_SIZE_16K)
			return cartDetectPkg::BANK_F6;
		if (size <= `CD_SIZE_32K)
			return cartDetectPkg::BANK_F4;
		if (size < `CD_SIZE_64K)
			return cartDetectPkg::BANK_32;
		if (size == `CD_SIZE_64K)
			return cartDetectPkg::BANK_F0;
		return cartDetectPkg::BANK_NONE;
	endfunction

	// SuperChip RAM only exists on F8, F6 and F4 boards
	function automatic bit expectedSuperChip(input logic [`CD_BANK_CODE_W-1:0] code, input int len);
		if (code != cartDetectPkg::BANK_F8 && code != cartDetectPkg::BANK_F6 &&
			code != cartDetectPkg::BANK_F4)
			return 1'b0;
		return superChipSeen(len);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/cartDetect.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module cartDetect (
	input logic clk,
	input logic reset,
	input logic enable,                              // Loader byte strobe
	input logic [`CD_ADDR_W-1:0] addr,
	input logic [`CD_DATA_W-1:0] data,
	input logic [`CD_SIZE_W-1:0] cartSize,           // Held during a scan
	output logic [`CD_BANK_CODE_W-1:0] bankType,
	output logic superChip
);

	scanBus scan ();
	evidenceBus evidence ();

	// ------------------------------------------------------------------------
	// Stage 1, byte window
	// ------------------------------------------------------------------------
	byteWindow window (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.addr(addr),
		.data(data),
		.out(scan.source)
	);

	// Stage 2, evidence from signatures and from the RAM mirror
	signatureMatcher matcher (
		.clk(clk),
		.reset(reset),
		.in(scan.sink),
		.evidence(evidence.matchSide)
	);

	superChipCheck scCheck (
		.clk(clk),
		.reset(reset),
		.in(scan.sink),
		.evidence(evidence.scSide)
	);

	// Stage 3, final code
	bankClassifier classifier (
		.clk(clk),
		.reset(reset),
		.cartSize(cartSize),
		.evidence(evidence.classSide),
		.bankType(bankType),
		.superChip(superChip)
	);

endmodule

`default_nettype wire

// ==== hdl/bankClassifier.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module bankClassifier (
	input logic clk,
	input logic reset,
	input logic [`CD_SIZE_W-1:0] cartSize,
	evidenceBus.classSide evidence,
	output logic [`CD_BANK_CODE_W-1:0] bankType,
	output logic superChip
);

	logic [`CD_BANK_CODE_W-1:0] typeNext;
	logic scAllowed;    // Only F8, F6 and F4 carts carry SuperChip RAM

	// ------------------------------------------------------------------------
	// First matching rule wins, signatures ahead of plain size
	// ------------------------------------------------------------------------
	always_comb begin
		scAllowed = 1'b0;
		if (evidence.hasFE)
			typeNext = cartDetectPkg::BANK_FE;
		else if (evidence.hasE0 && cartSize == `CD_SIZE_8K)
			typeNext = cartDetectPkg::BANK_E0;
		else if (evidence.has3F && cartSize > `CD_SIZE_4K)
			typeNext = cartDetectPkg::BANK_3F;
		else if (evidence.hasCV)
			typeNext = cartDetectPkg::BANK_CV;
		else if (evidence.hasE7)
			typeNext = cartDetectPkg::BANK_E7;
		else if (evidence.hasUA && cartSize == `CD_SIZE_8K)
			typeNext = cartDetectPkg::BANK_UA;
		else if (cartSize <= `CD_SIZE_2K)
			typeNext = cartDetectPkg::BANK_2K;
		else if (cartSize <= `CD_SIZE_4K)
			typeNext = cartDetectPkg::BANK_4K;    // No banking at all
		else if (cartSize <= `CD_SIZE_8K) begin
			typeNext = cartDetectPkg::BANK_F8;
			scAllowed = 1'b1;
		end else if (cartSize <= `CD_SIZE_12K)
			typeNext = cartDetectPkg::BANK_FA;
		else if (cartSize <= `CD_SIZE_16K) begin
			typeNext = cartDetectPkg::BANK_F6;
			scAllowed = 1'b1;
		end else if (cartSize <= `CD_SIZE_32K) begin
			typeNext = cartDetectPkg::BANK_F4;
			scAllowed = 1'b1;
		end else if (cartSize < `CD_SIZE_64K)
			typeNext = cartDetectPkg::BANK_32;
		else if (cartSize == `CD_SIZE_64K)
			typeNext = cartDetectPkg::BANK_F0;
		else
			typeNext = cartDetectPkg::BANK_NONE;    // Larger than any known scheme
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bankType <= cartDetectPkg::BANK_NONE;
			superChip <= 1'b0;
		end else begin
			bankType <= typeNext;
			superChip <= scAllowed & evidence.hasSc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/superChipCheck.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module superChipCheck (
	input logic clk,
	input logic reset,
	scanBus.sink in,
	evidenceBus.scSide evidence
);

	localparam logic [`CD_ADDR_W-1:0] Bank1Base = `CD_BANK1_BASE;
	localparam logic [`CD_ADDR_W-1:0] ScHalf = `CD_SC_HALF;
	localparam logic [`CD_ADDR_W-1:0] ScEnd = `CD_SC_END;

	logic [31:0] crcLow;     // Offsets 0 to 127
	logic [31:0] crcHigh;    // Offsets 128 to 255
	logic inBank0;
	logic inRange;
	logic [`CD_ADDR_W-1:0] offset;
	logic crcMatch;

	// ------------------------------------------------------------------------
	// Locate the byte inside the RAM area of bank 0 or bank 1
	// ------------------------------------------------------------------------
	assign inBank0 = (in.addr < Bank1Base);
	assign offset = inBank0 ? in.addr : in.addr - Bank1Base;
	assign inRange = (offset <= ScEnd) &&
		(inBank0 || in.addr < Bank1Base + Bank1Base);    // Only banks 0 and 1
	assign crcMatch = (crcLow == crcHigh);

	always_ff @(posedge clk) begin
		if (reset) begin
			crcLow <= '0;
			crcHigh <= '0;
			evidence.hasSc <= 1'b0;
		end else if (in.valid && inRange) begin
			if (offset == '0) begin
				// Fresh bank, seed both halves
				crcLow <= cartDetectPkg::nextCrc32D8(in.data, '0);
				crcHigh <= '0;
				if (in.restart)
					evidence.hasSc <= 1'b0;
			end else if (offset < ScHalf) begin
				crcLow <= cartDetectPkg::nextCrc32D8(in.data, crcLow);
			end else if (offset < ScEnd) begin
				crcHigh <= cartDetectPkg::nextCrc32D8(in.data, crcHigh);
			end else begin
				// Verdict at offset 256, bank 1 can only confirm bank 0
				if (inBank0)
					evidence.hasSc <= crcMatch;
				else
					evidence.hasSc <= evidence.hasSc & crcMatch;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/signatureMatcher.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module signatureMatcher (
	input logic clk,
	input logic reset,
	scanBus.sink in,
	evidenceBus.matchSide evidence
);

	localparam int DataW = `CD_DATA_W;
	localparam int SigCount = `CD_SIG_COUNT;
	localparam logic [`CD_COUNT_W-1:0] CountMax = '1;

	logic [`CD_COUNT_W-1:0] sigCount [SigCount];     // Occurrences so far
	logic [`CD_COUNT_W-1:0] sigNext [SigCount];
	logic [SigCount-1:0] sigHit;                     // Window ends in this signature
	logic [cartDetectPkg::FAM_COUNT-1:0] famNext;

	// ------------------------------------------------------------------------
	// Compare the newest bytes of the window against every table entry
	// ------------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < SigCount; i++) begin
			sigHit[i] = 1'b1;
			for (int b = 0; b < `CD_WINDOW_BYTES; b++) begin
				if (b < cartDetectPkg::sigLength[i] &&
					in.window[b*DataW +: DataW] != cartDetectPkg::sigBytes[i][b*DataW +: DataW])
					sigHit[i] = 1'b0;
			end
		end
	end

	// Next counter values, restart wipes history first
	always_comb begin
		for (int i = 0; i < SigCount; i++) begin
			sigNext[i] = in.restart ? '0 : sigCount[i];
			if (sigHit[i] && sigNext[i] != CountMax)
				sigNext[i] = sigNext[i] + 1'b1;    // Saturate, only reaching 2 matters
		end
	end

	// Family flag is the OR of its fired signatures
	always_comb begin
		famNext = '0;
		for (int i = 0; i < SigCount; i++) begin
			if (sigNext[i] >= cartDetectPkg::sigNeeded[i])
				famNext[cartDetectPkg::sigFamily[i]] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < SigCount; i++)
				sigCount[i] <= '0;
			evidence.has3F <= 1'b0;
			evidence.hasE0 <= 1'b0;
			evidence.hasE7 <= 1'b0;
			evidence.hasFE <= 1'b0;
			evidence.hasCV <= 1'b0;
			evidence.hasUA <= 1'b0;
		end else if (in.valid) begin
			for (int i = 0; i < SigCount; i++)
				sigCount[i] <= sigNext[i];
			evidence.has3F <= famNext[cartDetectPkg::FAM_3F];
			evidence.hasE0 <= famNext[cartDetectPkg::FAM_E0];
			evidence.hasE7 <= famNext[cartDetectPkg::FAM_E7];
			// A repeated F8 hotspot store means this is not FE
			evidence.hasFE <= famNext[cartDetectPkg::FAM_FE] & ~famNext[cartDetectPkg::FAM_F8];
			evidence.hasCV <= famNext[cartDetectPkg::FAM_CV];
			evidence.hasUA <= famNext[cartDetectPkg::FAM_UA];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/byteWindow.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

module byteWindow (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic [`CD_ADDR_W-1:0] addr,
	input logic [`CD_DATA_W-1:0] data,
	scanBus.source out
);

	localparam int DataW = `CD_DATA_W;
	localparam int WinW = `CD_WINDOW_BYTES * `CD_DATA_W;

	logic restartNow;

	assign restartNow = (addr == '0);    // Loader always begins an image at 0

	// Control and window history
	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
			out.window <= '0;
		end else begin
			out.valid <= enable;
			if (enable) begin
				// Drop older bytes on a new image so no match straddles two loads
				if (restartNow)
					out.window <= WinW'(data);
				else
					out.window <= {out.window[WinW-DataW-1:0], data};
			end
		end
	end

	// Byte payload, qualified by valid downstream
	always_ff @(posedge clk) begin
		if (enable) begin
			out.addr <= addr;
			out.data <= data;
			out.restart <= restartNow;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cartDetectIfs.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

// ----------------------------------------------------------------------------
// Byte stream after the window stage
// ----------------------------------------------------------------------------
interface scanBus;
	logic valid;                                              // One cycle per byte
	logic [`CD_ADDR_W-1:0] addr;
	logic [`CD_DATA_W-1:0] data;
	logic restart;                                            // Byte sits at address 0
	logic [`CD_WINDOW_BYTES*`CD_DATA_W-1:0] window;           // Newest byte in low lane

	modport source (output valid, output addr, output data, output restart, output window);
	modport sink (input valid, input addr, input data, input restart, input window);
endinterface

// ----------------------------------------------------------------------------
// Evidence flags collected over one image
// ----------------------------------------------------------------------------
interface evidenceBus;
	logic has3F;
	logic hasE0;
	logic hasE7;
	logic hasFE;    // Already vetoed by F8
	logic hasCV;
	logic hasUA;
	logic hasSc;    // SuperChip mirror seen

	modport matchSide (output has3F, output hasE0, output hasE7, output hasFE,
		output hasCV, output hasUA);
	modport scSide (output hasSc);
	modport classSide (input has3F, input hasE0, input hasE7, input hasFE,
		input hasCV, input hasUA, input hasSc);
endinterface

`default_nettype wire

// ==== hdl/cartDetectPkg.sv ====
`default_nettype none

`include "cartDetect_cfg.svh"

package cartDetectPkg;

	// ------------------------------------------------------------------------
	// Signature families
	// ------------------------------------------------------------------------
	localparam int FAM_3F = 0;
	localparam int FAM_E0 = 1;
	localparam int FAM_E7 = 2;
	localparam int FAM_FE = 3;
	localparam int FAM_F8 = 4;    // Only used as a veto on FE
	localparam int FAM_CV = 5;
	localparam int FAM_UA = 6;
	localparam int FAM_COUNT = 7;

	// Signature bytes in stream order, last byte in the low lane
	localparam logic [`CD_WINDOW_BYTES*`CD_DATA_W-1:0] sigBytes [`CD_SIG_COUNT] = '{
		40'h00_0000_853F,                            // STA $3F
		40'h00_008D_E01F, 40'h00_008D_E05F,          // STA $1FE0, STA $5FE0
		40'h00_008D_E9FF, 40'h00_000C_E01F,          // STA $FFE9, NOP $1FE0
		40'h00_00AD_E01F, 40'h00_00AD_E9FF,          // LDA $1FE0, LDA $FFE9
		40'h00_00AD_EDFF, 40'h00_00AD_F3BF,          // LDA $FFED, LDA $BFF3
		40'h00_00AD_E2FF, 40'h00_00AD_E5FF,          // LDA $FFE2, LDA $FFE5
		40'h00_00AD_E51F, 40'h00_00AD_E71F,          // LDA $1FE5, LDA $1FE7
		40'h00_000C_E71F, 40'h00_008D_E7FF,          // NOP $1FE7, STA $FFE7
		40'h00_008D_E71F,                            // STA $1FE7
		40'h00_008D_F91F, 40'h00_008D_F9FF,          // STA $1FF9, STA $FFF9
		40'h20_00D0_C6C5,                            // JSR $D000; DEC $C5
		40'h20_C3F8_A582,                            // JSR $F8C3; LDA $82
		40'hD0_FB20_73FE,                            // BNE; JSR $FE73
		40'h20_00F0_84D6,                            // JSR $F000; STY $D6
		40'h00_009D_FFF3, 40'h00_0099_00F4,          // STA $F3FF,X / STA $F400,Y
		40'h00_008D_4002, 40'h00_00AD_4002,          // STA $240, LDA $240
		40'h00_00BD_1F02, 40'h00_002C_C002,          // LDA $21F,X, BIT $2C0
		40'h00_008D_C002, 40'h00_00AD_C002,          // STA $2C0, LDA $2C0
		40'h00_002C_C00F                             // BIT $FC0
	};

	// Bytes per signature
	localparam logic [2:0] sigLength [`CD_SIG_COUNT] = '{
		3'd2,
		3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3,
		3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3,
		3'd3, 3'd3,
		3'd5, 3'd5, 3'd5, 3'd5,
		3'd3, 3'd3,
		3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3
	};

	// Occurrences before a signature counts as evidence
	localparam logic [`CD_COUNT_W-1:0] sigNeeded [`CD_SIG_COUNT] = '{
		2'd2,
		2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1,
		2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1,
		2'd2, 2'd2,
		2'd1, 2'd1, 2'd1, 2'd1,
		2'd1, 2'd1,
		2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1
	};

	localparam logic [2:0] sigFamily [`CD_SIG_COUNT] = '{
		3'(FAM_3F),
		3'(FAM_E0), 3'(FAM_E0), 3'(FAM_E0), 3'(FAM_E0),
		3'(FAM_E0), 3'(FAM_E0), 3'(FAM_E0), 3'(FAM_E0),
		3'(FAM_E7), 3'(FAM_E7), 3'(FAM_E7), 3'(FAM_E7),
		3'(FAM_E7), 3'(FAM_E7), 3'(FAM_E7),
		3'(FAM_F8), 3'(FAM_F8),
		3'(FAM_FE), 3'(FAM_FE), 3'(FAM_FE), 3'(FAM_FE),
		3'(FAM_CV), 3'(FAM_CV),
		3'(FAM_UA), 3'(FAM_UA), 3'(FAM_UA), 3'(FAM_UA),
		3'(FAM_UA), 3'(FAM_UA), 3'(FAM_UA)
	};

	// ------------------------------------------------------------------------
	// Bankswitch codes as seen by the 2600 core
	// ------------------------------------------------------------------------
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_NONE = 4'd0;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_F8   = 4'd1;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_F6   = 4'd2;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_FE   = 4'd3;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_E0   = 4'd4;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_3F   = 4'd5;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_F4   = 4'd6;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_FA   = 4'd8;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_CV   = 4'd9;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_2K   = 4'd10;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_UA   = 4'd11;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_E7   = 4'd12;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_F0   = 4'd13;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_32   = 4'd14;
	localparam logic [`CD_BANK_CODE_W-1:0] BANK_4K   = 4'd15;

	localparam logic [31:0] CRC32_POLY = 32'h04C1_1DB7;

	// CRC-32 over one byte, MSB first
	function automatic logic [31:0] nextCrc32D8(
		input logic [`CD_DATA_W-1:0] data,
		input logic [31:0] crc
	);
		logic [31:0] c;
		logic fb;
		c = crc;
		for (int i = `CD_DATA_W - 1; i >= 0; i--) begin
			fb = c[31] ^ data[i];
			c = {c[30:0], 1'b0};
			if (fb)
				c = c ^ CRC32_POLY;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== include/cartDetect_cfg.svh ====
`ifndef CART_DETECT_CFG_SVH
`define CART_DETECT_CFG_SVH

// Load bus widths
`define CD_ADDR_W        16
`define CD_DATA_W        8
`define CD_SIZE_W        32

`define CD_WINDOW_BYTES  5         // Longest signature (FE family)
`define CD_SIG_COUNT     31        // Entries in the signature table
`define CD_COUNT_W       2         // Saturating occurrence counter

// SuperChip RAM mirror window, offsets inside a 4K bank
`define CD_SC_HALF       128
`define CD_SC_END        256
`define CD_BANK1_BASE    4096

// Cartridge size thresholds in bytes
`define CD_SIZE_2K       32'h0000_0800
`define CD_SIZE_4K       32'h0000_1000
`define CD_SIZE_8K       32'h0000_2000
`define CD_SIZE_12K      32'h0000_3000
`define CD_SIZE_16K      32'h0000_4000
`define CD_SIZE_32K      32'h0000_8000
`define CD_SIZE_64K      32'h0001_0000

`define CD_BANK_CODE_W   4

`endif
